// File: logic/rp_defs.svh
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

////////////////////
// Analog samples
////////////////////

// Used ADC/DAC resolution
`define RP_SMP_W 14
// Calibration gain word
`define RP_GAIN_W 16
// Gain of 16'h4000 passes samples unchanged
`define RP_GAIN_SHIFT 14
// Raw ADC pin bus, bits 1:0 not connected on 14 bit parts
`define RP_ADC_PIN_W 16
// Channels per direction
`define RP_CHN 2

////////////////////
// PDM outputs
////////////////////

// Level resolution
`define RP_PDM_W 8
// Number of outputs
`define RP_PDM_CHN 4

`endif

// File: logic/rp_pkg.sv
`include "rp_defs.svh"

package rp_pkg;

  ////////////////////
  // Sample types
  ////////////////////

  // Two's complement sample inside the data path
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // Raw word as seen on the ADC pins
  typedef logic [`RP_ADC_PIN_W-1:0] adc_pin_t;

  // Inverted offset binary code for the DAC pins
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  ////////////////////
  // Calibration
  ////////////////////

  // Fixed point gain, unity at 1 << RP_GAIN_SHIFT
  typedef logic signed [`RP_GAIN_W-1:0] gain_t;

  // Offset added after scaling
  typedef logic signed [`RP_SMP_W-1:0] offset_t;

  // Gain and offset pair for one stream
  typedef struct packed {
    gain_t   gain;
    offset_t offset;
  } calib_t;

  ////////////////////
  // Streams
  ////////////////////

  // Sample stream, no back pressure
  typedef struct packed {
    logic    valid;
    sample_t data;
  } smp_str_t;

  // PDM duty level
  typedef logic [`RP_PDM_W-1:0] pdm_lvl_t;

endpackage: rp_pkg

// File: logic/calib_linear.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module calib_linear (
  input  logic             adc_clk,
  input  logic             top_rst,
  // Stream in/out
  input  rp_pkg::smp_str_t str_i,
  output rp_pkg::smp_str_t str_o,
  // Gain and offset, level input
  input  rp_pkg::calib_t   cal_i
);

  import rp_pkg::*;

  // Full product and the post-shift sum with headroom
  typedef logic signed [`RP_SMP_W+`RP_GAIN_W-1:0] prod_t;
  typedef logic signed [`RP_SMP_W+`RP_GAIN_W:0]   sum_t;

  sample_t smp_in;
  gain_t   gain_in;
  prod_t   mul_d;
  prod_t   mul_q;
  offset_t off_q;
  logic    vld_q;
  sum_t    sum;
  logic    sat_ok;
  sample_t sat_d;
  sample_t out_dat_q;
  logic    out_vld_q;

  ////////////////////
  // Stage one
  ////////////////////

  // Signed operands for the multiplier
  assign smp_in  = str_i.data;
  assign gain_in = cal_i.gain;
  assign mul_d   = smp_in * gain_in;

  // Valid follows the data
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= str_i.valid;
    end
  end

  // Offset sampled with its product
  always_ff @(posedge adc_clk) begin
    mul_q <= mul_d;
    off_q <= cal_i.offset;
  end

  ////////////////////
  // Stage two
  ////////////////////

  // Drop fraction bits, then add offset
  assign sum = sum_t'(mul_q >>> `RP_GAIN_SHIFT) + sum_t'(off_q);

  // In range when all bits above the sample MSB match it
  assign sat_ok = (&sum[`RP_SMP_W+`RP_GAIN_W:`RP_SMP_W-1]) |
                  ~(|sum[`RP_SMP_W+`RP_GAIN_W:`RP_SMP_W-1]);

  always_comb begin
    if (sat_ok) begin
      sat_d = sum[`RP_SMP_W-1:0];
    end else if (sum[`RP_SMP_W+`RP_GAIN_W]) begin
      // Clip to most negative
      sat_d = {1'b1, {(`RP_SMP_W-1){1'b0}}};
    end else begin
      // Clip to most positive
      sat_d = {1'b0, {(`RP_SMP_W-1){1'b1}}};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      out_vld_q <= 1'b0;
    end else begin
      out_vld_q <= vld_q;
    end
  end

  always_ff @(posedge adc_clk) begin
    out_dat_q <= sat_d;
  end

  assign str_o = '{valid: out_vld_q, data: out_dat_q};

endmodule: calib_linear

// File: logic/adc_frontend.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module adc_frontend (
  input  logic             adc_clk,
  input  logic             top_rst,
  // Raw pins, two LSBs unused
  input  rp_pkg::adc_pin_t adc_pin_i,
  // Digital loopback from the DAC side
  input  logic             loop_i,
  input  rp_pkg::smp_str_t loop_str_i,
  // Calibration
  input  rp_pkg::calib_t   cal_i,
  // Calibrated samples
  output rp_pkg::smp_str_t adc_smp_o
);

  import rp_pkg::*;

  sample_t  raw_q;
  logic     raw_vld_q;
  smp_str_t pin_str;
  smp_str_t sel_str;

  ////////////////////
  // Pin conversion
  ////////////////////

  // Offset binary with inverted slope to two's complement
  // Sign bit kept, magnitude bits inverted
  always_ff @(posedge adc_clk) begin
    raw_q <= {adc_pin_i[`RP_ADC_PIN_W-1],
              ~adc_pin_i[`RP_ADC_PIN_W-2:`RP_ADC_PIN_W-`RP_SMP_W]};
  end

  // ADC delivers a sample every clock
  // Valid rises once the first pin word is in
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_vld_q <= 1'b0;
    end else begin
      raw_vld_q <= 1'b1;
    end
  end

  assign pin_str = '{valid: raw_vld_q, data: raw_q};

  ////////////////////
  // Loopback select
  ////////////////////

  // Looped DAC stream skips the conversion register
  assign sel_str = loop_i ? loop_str_i : pin_str;

  ////////////////////
  // Calibration
  ////////////////////

  calib_linear calib_adc (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .str_i   (sel_str),
    .str_o   (adc_smp_o),
    .cal_i   (cal_i)
  );

endmodule: adc_frontend

// File: logic/dac_backend.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module dac_backend (
  input  logic              adc_clk,
  input  logic              top_rst,
  // Generator samples
  input  rp_pkg::smp_str_t  gen_smp_i,
  // Calibration
  input  rp_pkg::calib_t    cal_i,
  // Calibrated stream, also used for loopback
  output rp_pkg::smp_str_t  dac_str_o,
  // DAC pin code
  output rp_pkg::dac_code_t dac_dat_o
);

  import rp_pkg::*;

  smp_str_t cal_str;
  sample_t  cal_dat;

  ////////////////////
  // Calibration
  ////////////////////

  calib_linear calib_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .str_i   (gen_smp_i),
    .str_o   (cal_str),
    .cal_i   (cal_i)
  );

  // Same stream goes to the ADC side
  assign dac_str_o = cal_str;
  assign cal_dat   = cal_str.data;

  ////////////////////
  // Pin code
  ////////////////////

  // Two's complement back to offset binary
  // DAC has negative slope, so magnitude bits flip
  // Code held between valid samples
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else if (cal_str.valid) begin
      dac_dat_o <= {cal_dat[`RP_SMP_W-1], ~cal_dat[`RP_SMP_W-2:0]};
    end
  end

endmodule: dac_backend

// File: logic/pdm_modulator.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module pdm_modulator (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  // Duty levels, one per output
  input  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] lvl_i,
  // Pulse density outputs
  output logic             [`RP_PDM_CHN-1:0] pdm_o
);

  import rp_pkg::*;

  // First order accumulators
  pdm_lvl_t [`RP_PDM_CHN-1:0]            acc_q;
  // Accumulator plus level, carry in the MSB
  logic     [`RP_PDM_CHN-1:0][`RP_PDM_W:0] sum;

  ////////////////////
  // Accumulate
  ////////////////////

  always_comb begin
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      sum[i] = {1'b0, acc_q[i]} + {1'b0, lvl_i[i]};
    end
  end

  // Carry count over 256 clocks equals the level
  // Accumulator wraps, keeping the residue
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        acc_q[i] <= sum[i][`RP_PDM_W-1:0];
        pdm_o[i] <= sum[i][`RP_PDM_W];
      end
    end
  end

endmodule: pdm_modulator

// File: logic/rp_top.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_top (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC pins and calibration
  input  rp_pkg::adc_pin_t  [`RP_CHN-1:0]     adc_dat_i,
  input  logic              [`RP_CHN-1:0]     mux_loop_i,
  input  rp_pkg::calib_t    [`RP_CHN-1:0]     adc_cal_i,
  // Generator streams and DAC calibration
  input  rp_pkg::smp_str_t  [`RP_CHN-1:0]     gen_smp_i,
  input  rp_pkg::calib_t    [`RP_CHN-1:0]     dac_cal_i,
  // PDM levels
  input  rp_pkg::pdm_lvl_t  [`RP_PDM_CHN-1:0] pdm_lvl_i,
  // Calibrated ADC streams
  output rp_pkg::smp_str_t  [`RP_CHN-1:0]     adc_smp_o,
  // DAC pin codes, one register per channel
  output rp_pkg::dac_code_t [`RP_CHN-1:0]     dac_dat_o,
  // PDM outputs
  output logic              [`RP_PDM_CHN-1:0] dac_pwm_o
);

  import rp_pkg::*;

  // Calibrated DAC streams, feed the ADC loopback
  smp_str_t [`RP_CHN-1:0] dac_str;

  ////////////////////
  // DAC channels
  ////////////////////

  generate
    for (genvar i = 0; i < `RP_CHN; i++) begin: g_dac
      dac_backend dac_backend (
        .adc_clk   (adc_clk),
        .top_rst   (top_rst),
        .gen_smp_i (gen_smp_i[i]),
        .cal_i     (dac_cal_i[i]),
        .dac_str_o (dac_str[i]),
        .dac_dat_o (dac_dat_o[i])
      );
    end: g_dac
  endgenerate

  ////////////////////
  // ADC channels
  ////////////////////

  // Loopback takes the DAC stream of the same channel
  generate
    for (genvar i = 0; i < `RP_CHN; i++) begin: g_adc
      adc_frontend adc_frontend (
        .adc_clk    (adc_clk),
        .top_rst    (top_rst),
        .adc_pin_i  (adc_dat_i[i]),
        .loop_i     (mux_loop_i[i]),
        .loop_str_i (dac_str[i]),
        .cal_i      (adc_cal_i[i]),
        .adc_smp_o  (adc_smp_o[i])
      );
    end: g_adc
  endgenerate

  ////////////////////
  // PDM outputs
  ////////////////////

  // All four levels run from adc_clk
  pdm_modulator pdm_modulator (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl_i),
    .pdm_o   (dac_pwm_o)
  );

endmodule: rp_top

// File: verif/rp_top_tb.sv
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_top_tb;

  import rp_pkg::*;

  logic                               adc_clk;
  logic                               top_rst;
  adc_pin_t  [`RP_CHN-1:0]            adc_dat;
  logic      [`RP_CHN-1:0]            mux_loop;
  calib_t    [`RP_CHN-1:0]            adc_cal;
  smp_str_t  [`RP_CHN-1:0]            gen_smp;
  calib_t    [`RP_CHN-1:0]            dac_cal;
  pdm_lvl_t  [`RP_PDM_CHN-1:0]        pdm_lvl;
  smp_str_t  [`RP_CHN-1:0]            adc_smp;
  dac_code_t [`RP_CHN-1:0]            dac_dat;
  logic      [`RP_PDM_CHN-1:0]        dac_pwm;

  // Expected values, ADC keep flag clears samples hit by a calibration change
  sample_t   adc_q[`RP_CHN][$];
  bit        adc_k[`RP_CHN][$];
  dac_code_t dac_q[`RP_CHN][$];

  // Per channel mode of the stimulus and compare processes
  bit        pin_mode[`RP_CHN];
  bit        loop_mode[`RP_CHN];
  bit        strict[`RP_CHN];
  bit        gap_on[`RP_CHN];
  bit        gen_en;
  calib_t    adc_cal_cur[`RP_CHN];
  calib_t    dac_cal_cur[`RP_CHN];
  dac_code_t dac_last[`RP_CHN];
  dac_code_t dac_prev[`RP_CHN];
  int        seed;

  rp_top uut (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat),
    .mux_loop_i (mux_loop),
    .adc_cal_i  (adc_cal),
    .gen_smp_i  (gen_smp),
    .dac_cal_i  (dac_cal),
    .pdm_lvl_i  (pdm_lvl),
    .adc_smp_o  (adc_smp),
    .dac_dat_o  (dac_dat),
    .dac_pwm_o  (dac_pwm)
  );

  // 50 MHz
  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Sign bit stays, slope inverted on the other 13 bits
  function automatic sample_t adc_conv(adc_pin_t pin);
    return {pin[15], ~pin[14:2]};
  endfunction

  // Scale, drop fraction, add offset, clip to 14 bit signed
  function automatic sample_t calib(sample_t s, calib_t c);
    longint p;
    p = longint'(s) * longint'(c.gain);
    p = p >>> `RP_GAIN_SHIFT;
    p = p + longint'(c.offset);
    if (p > 8191) p = 8191;
    if (p < -8192) p = -8192;
    return sample_t'(p);
  endfunction

  function automatic dac_code_t dac_code(sample_t s);
    return {s[13], ~s[12:0]};
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_sample(string name, sample_t got, sample_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run("sample mismatch");
    end
  endtask

  task automatic check_dac_code(string name, dac_code_t got, dac_code_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run("DAC code mismatch");
    end
  endtask

  task automatic check_pdm_count(string name, int got, int exp);
    if (got != exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run("PDM count mismatch");
    end
  endtask

  // Outputs sampled on the falling edge, away from the driving edge
  always @(negedge adc_clk) begin
    sample_t   exp_s;
    bit        keep;
    dac_code_t exp_d;
    if (!top_rst) begin
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        if (adc_smp[ch].valid) begin
          if (adc_q[ch].size() > 0) begin
            exp_s = adc_q[ch].pop_front();
            keep  = adc_k[ch].pop_front();
            if (keep) begin
              check_sample($sformatf("adc_smp_o[%0d]", ch), adc_smp[ch].data, exp_s);
            end
          end else if (strict[ch]) begin
            abort_run("ADC output valid with no sample expected");
          end
          if (pin_mode[ch]) gap_on[ch] = 1'b1;
        end else if (gap_on[ch]) begin
          abort_run("ADC valid dropped while pins stream");
        end
        // A new code means a new calibrated DAC sample
        if (dac_dat[ch] != dac_prev[ch]) begin
          if (dac_q[ch].size() == 0) begin
            abort_run("DAC code changed with no sample expected");
          end
          exp_d = dac_q[ch].pop_front();
          check_dac_code($sformatf("dac_dat_o[%0d]", ch), dac_dat[ch], exp_d);
          dac_prev[ch] = dac_dat[ch];
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // One clock of pins and generator samples
  task automatic tick();
    adc_pin_t  pin;
    sample_t   d;
    dac_code_t e;
    logic      v;
    @(posedge adc_clk);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      pin = adc_pin_t'($random(seed));
      adc_dat[ch] <= pin;
      if (pin_mode[ch]) begin
        adc_q[ch].push_back(calib(adc_conv(pin), adc_cal_cur[ch]));
        adc_k[ch].push_back(1'b1);
      end
      // Roughly one idle cycle in four
      v = gen_en && ($random(seed) % 4 != 0);
      d = '0;
      if (v) begin
        // Consecutive codes differ so each one shows as a change
        do begin
          d = sample_t'($random(seed));
          e = dac_code(calib(d, dac_cal_cur[ch]));
        end while (e == dac_last[ch]);
        dac_last[ch] = e;
        dac_q[ch].push_back(e);
        if (loop_mode[ch]) begin
          adc_q[ch].push_back(calib(calib(d, dac_cal_cur[ch]), adc_cal_cur[ch]));
          adc_k[ch].push_back(1'b1);
        end
      end
      gen_smp[ch] <= '{valid: v, data: d};
    end
  endtask

  // New ADC calibration, samples still in the pipe are not compared
  task automatic set_adc_cal(int ch, calib_t c);
    int n;
    adc_cal[ch] <= c;
    adc_cal_cur[ch] = c;
    n = adc_q[ch].size();
    for (int k = 1; k <= 3; k++) begin
      if (n >= k) adc_k[ch][n-k] = 1'b0;
    end
  endtask

  initial begin
    calib_t c;
    int     cnt[`RP_PDM_CHN];
    int     w;
    seed = 32'h871f_8c50;
    top_rst  = 1'b1;
    adc_dat  = '0;
    mux_loop = '0;
    gen_smp  = '0;
    pdm_lvl  = '0;
    gen_en   = 1'b0;
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      adc_cal_cur[ch] = '{gain: gain_t'(16'h4000), offset: '0};
      c.gain   = gain_t'(16'h2000 + ({$random(seed)} % 32'h4000));
      c.offset = offset_t'($random(seed) % 256);
      dac_cal_cur[ch] = c;
      dac_last[ch]    = '0;
      dac_prev[ch]    = '0;
      pin_mode[ch]    = 1'b0;
      loop_mode[ch]   = 1'b0;
      strict[ch]      = 1'b0;
      gap_on[ch]      = 1'b0;
      adc_cal[ch]     = adc_cal_cur[ch];
      dac_cal[ch]     = dac_cal_cur[ch];
    end

    // Reset for 4 cycles, state checked in the last one
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      if (adc_smp[ch].valid) abort_run("ADC valid high in reset");
      check_dac_code($sformatf("dac_dat_o[%0d]", ch), dac_dat[ch], '0);
    end
    check_pdm_count("dac_pwm_o", int'(dac_pwm), 0);
    @(posedge adc_clk);
    top_rst <= 1'b0;

    ////////////////////
    // ADC and DAC paths
    ////////////////////

    // Pins tracked from the release edge on
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      pin_mode[ch] = 1'b1;
      strict[ch]   = 1'b1;
      // Word held since reset is the first one the ADC sees
      adc_q[ch].push_back(calib(adc_conv(adc_dat[ch]), adc_cal_cur[ch]));
      adc_k[ch].push_back(1'b1);
    end
    repeat (40) tick();
    // Full range gains, saturation included
    gen_en = 1'b1;
    repeat (6) begin
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        c.gain   = gain_t'($random(seed));
        c.offset = offset_t'($random(seed));
        set_adc_cal(ch, c);
      end
      repeat (30) tick();
    end

    ////////////////////
    // Loopback
    ////////////////////

    // Channel 0 switched over, pipe flushed with the generator idle
    gen_en = 1'b0;
    tick();
    pin_mode[0] = 1'b0;
    gap_on[0]   = 1'b0;
    strict[0]   = 1'b0;
    adc_q[0].delete();
    adc_k[0].delete();
    mux_loop[0] <= 1'b1;
    repeat (10) tick();
    loop_mode[0] = 1'b1;
    strict[0]    = 1'b1;
    gen_en       = 1'b1;
    repeat (80) tick();

    // Drain every queue
    gen_en = 1'b0;
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      // Untracked pins keep the ADC valid high
      if (pin_mode[ch]) strict[ch] = 1'b0;
      pin_mode[ch] = 1'b0;
      gap_on[ch]   = 1'b0;
    end
    w = 0;
    while (w < 100 && (adc_q[0].size() + adc_q[1].size() +
                       dac_q[0].size() + dac_q[1].size()) > 0) begin
      tick();
      w++;
    end
    if (w == 100) abort_run("expected samples never arrived");
    for (int ch = 0; ch < `RP_CHN; ch++) strict[ch] = 1'b0;

    ////////////////////
    // PDM
    ////////////////////

    repeat (4) begin
      @(posedge adc_clk);
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        pdm_lvl[i] <= pdm_lvl_t'($random(seed));
      end
      repeat (4) @(posedge adc_clk);
      for (int i = 0; i < `RP_PDM_CHN; i++) cnt[i] = 0;
      // Any 256 cycle window
      repeat (256) begin
        @(negedge adc_clk);
        for (int i = 0; i < `RP_PDM_CHN; i++) begin
          cnt[i] = cnt[i] + int'(dac_pwm[i]);
        end
      end
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        check_pdm_count($sformatf("dac_pwm_o[%0d]", i), cnt[i], int'(pdm_lvl[i]));
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule: rp_top_tb

// File: files.f
+incdir+logic
logic/rp_pkg.sv
logic/calib_linear.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/pdm_modulator.sv
logic/rp_top.sv
verif/rp_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := rp_top_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
